// File: logic/arch_pkg.sv
/*
 * Architectural register facts for the rename stage.
 * Shared by the RTL and the testbench. Import what is needed.
 */

package arch_pkg;

  // ------------------------------------------------------------------------
  // Architectural register file
  // ------------------------------------------------------------------------

  // RISC-V style integer file, no special case for x0
  localparam int num_arch_regs = 32;

  // Index width
  localparam int areg_w = $clog2(num_arch_regs);

  // Destination and source register numbers
  typedef logic [areg_w-1:0] areg_t;

endpackage

// File: logic/phys_pkg.sv
/*
 * Physical register pool limits and the physical index type.
 * The pool size itself is a module parameter and must stay
 * inside the limits given here.
 */

package phys_pkg;

  // ------------------------------------------------------------------------
  // Pool limits
  // ------------------------------------------------------------------------

  // Largest pool the index type can address
  localparam int max_phys_regs = 64;

  // Smallest useful pool, one spare above the architectural set
  localparam int min_phys_regs = 33;

  // ------------------------------------------------------------------------
  // Index type
  // ------------------------------------------------------------------------

  // Sized for the largest pool, smaller pools leave top codes unused
  localparam int preg_w = $clog2(max_phys_regs);

  typedef logic [preg_w-1:0] preg_t;

endpackage

// File: logic/alloc_if.sv
/*
 * One rename allocation, shared by the free list, map table and pending
 * table. en/rdy call handshake, fires on an edge with both high.
 */

`timescale 1ns/10ps

interface alloc_if;

  import arch_pkg::*;
  import phys_pkg::*;

  // Request from the decode side
  logic  en;
  areg_t areg;

  // Free list answer, rdy means the queue is not empty
  logic  rdy;
  preg_t preg;

  // Old mapping of areg, handed back for later commit
  preg_t ppreg;

  modport free_list_mp (input en, output rdy, output preg);

  modport map_mp (input en, input rdy, input areg, input preg, output ppreg);

  // Listener only
  modport pend_mp (input en, input rdy, input preg);

  modport top_mp (output en, output areg, input rdy, input preg, input ppreg);

endinterface

// File: logic/free_list.sv
/*
 * Free physical register queue. Pops the head on an allocation handshake
 * and appends committed registers at the tail. Holds every register
 * above the architectural set after reset, in ascending order.
 */

`timescale 1ns/10ps

module free_list #(
  parameter int p_num_phys_regs = 36
) (
  input  logic           clk,
  input  logic           arst_n,
  alloc_if.free_list_mp  alloc,
  input  logic           commit_val,
  input  phys_pkg::preg_t commit_ppreg
);

  import arch_pkg::*;
  import phys_pkg::*;

  // ------------------------------------------------------------------------
  // Sizing
  // ------------------------------------------------------------------------

  // At most this many registers are unmapped at any time
  localparam int depth = p_num_phys_regs - num_arch_regs;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  // Pool size check at elaboration
  if (p_num_phys_regs < min_phys_regs || p_num_phys_regs > max_phys_regs) begin : g_bad_size
    $error("free_list: pool size %0d out of range", p_num_phys_regs);
  end

  // ------------------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------------------

  preg_t            entries [depth];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;

  logic pop;
  logic push;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == ptr_w'(depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign pop  = alloc.en && alloc.rdy;
  assign push = commit_val;

  // Head is offered combinationally
  assign alloc.rdy  = (count != '0);
  assign alloc.preg = entries[head];

  // Reset loads the spare registers, queue starts full
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        entries[i] <= preg_t'(num_arch_regs + i);
      end
    end else if (push) begin
      entries[tail] <= commit_ppreg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= cnt_w'(depth);
    end else begin
      if (pop) begin
        head <= bump(head);
      end
      if (push) begin
        tail <= bump(tail);
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Requester waits for rdy, so an empty queue is never asked
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    alloc.en |-> alloc.rdy)
    else $error("free_list: allocation requested while empty");

  // A full queue means every unmapped register is here already
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> (count < cnt_w'(depth)))
    else $error("free_list: commit into a full queue");

endmodule

// File: logic/map_table.sv
/*
 * Architectural to physical register map. Two combinational lookup
 * ports and one allocation port, written at the handshake edge.
 * Resets to the identity mapping.
 */

`timescale 1ns/10ps

module map_table (
  input  logic            clk,
  input  logic            arst_n,
  alloc_if.map_mp         alloc,
  input  arch_pkg::areg_t lookup0_areg,
  input  arch_pkg::areg_t lookup1_areg,
  output phys_pkg::preg_t lookup0_preg,
  output phys_pkg::preg_t lookup1_preg
);

  import arch_pkg::*;
  import phys_pkg::*;

  // ------------------------------------------------------------------------
  // Map storage
  // ------------------------------------------------------------------------

  preg_t map [num_arch_regs];
  logic  fire;

  assign fire = alloc.en && alloc.rdy;

  // Old mapping goes back with the new one in the same cycle
  assign alloc.ppreg = map[alloc.areg];

  // Lookups see the state of earlier edges only
  assign lookup0_preg = map[lookup0_areg];
  assign lookup1_preg = map[lookup1_areg];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Identity map puts areg n in preg n
      for (int i = 0; i < num_arch_regs; i++) begin
        map[i] <= preg_t'(i);
      end
    end else if (fire) begin
      map[alloc.areg] <= alloc.preg;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Free list must never hand out a register that is still mapped here
  a_fresh_preg: assert property (@(posedge clk) disable iff (!arst_n)
    fire |-> (alloc.preg != alloc.ppreg))
    else $error("map_table: allocated preg %0d equals old mapping", alloc.preg);

endmodule

// File: logic/pending_table.sv
/*
 * One pending bit per physical register. Set when the register is handed
 * out by an allocation, cleared by a completion notification. Two lookup
 * ports read the bits for the registers the map table returns.
 */

`timescale 1ns/10ps

module pending_table #(
  parameter int p_num_phys_regs = 36
) (
  input  logic            clk,
  input  logic            arst_n,
  alloc_if.pend_mp        alloc,
  input  logic            complete_val,
  input  phys_pkg::preg_t complete_preg,
  input  phys_pkg::preg_t lookup0_preg,
  input  phys_pkg::preg_t lookup1_preg,
  output logic            lookup0_pending,
  output logic            lookup1_pending
);

  // ------------------------------------------------------------------------
  // Pending bits
  // ------------------------------------------------------------------------

  logic [p_num_phys_regs-1:0] pend;
  logic                       fire;

  assign fire = alloc.en && alloc.rdy;

  // Zero latency read, completion shows one cycle later
  assign lookup0_pending = pend[lookup0_preg];
  assign lookup1_pending = pend[lookup1_preg];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend <= '0;
    end else begin
      // Targets differ in legal traffic, order does not matter
      if (complete_val) begin
        pend[complete_preg] <= 1'b0;
      end
      if (fire) begin
        pend[alloc.preg] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Only an outstanding producer can complete
  a_complete_pending: assert property (@(posedge clk) disable iff (!arst_n)
    complete_val |-> pend[complete_preg])
    else $error("pending_table: completion of idle preg %0d", complete_preg);

  // Registers in the free queue have no producer in flight
  a_free_not_pending: assert property (@(posedge clk) disable iff (!arst_n)
    fire |-> !pend[alloc.preg])
    else $error("pending_table: free preg %0d still pending", alloc.preg);

endmodule

// File: logic/rename_table.sv
/*
 * Register rename stage top level. Joins free list, map table and
 * pending table behind plain ports. Pool size set here and passed down.
 */

`timescale 1ns/10ps

module rename_table #(
  parameter int p_num_phys_regs = 36
) (
  input  logic            clk,
  input  logic            arst_n,

  // Allocation call
  input  logic            alloc_en,
  input  arch_pkg::areg_t alloc_areg,
  output logic            alloc_rdy,
  output phys_pkg::preg_t alloc_preg,
  output phys_pkg::preg_t alloc_ppreg,

  // Lookup ports
  input  logic            lookup0_en,
  input  arch_pkg::areg_t lookup0_areg,
  output phys_pkg::preg_t lookup0_preg,
  output logic            lookup0_pending,
  input  logic            lookup1_en,
  input  arch_pkg::areg_t lookup1_areg,
  output phys_pkg::preg_t lookup1_preg,
  output logic            lookup1_pending,

  // Notifications, no back-pressure
  input  logic            complete_val,
  input  phys_pkg::preg_t complete_preg,
  input  logic            commit_val,
  input  phys_pkg::preg_t commit_ppreg
);

  // ------------------------------------------------------------------------
  // Allocation bundle
  // ------------------------------------------------------------------------

  alloc_if alloc_bus ();

  assign alloc_bus.en   = alloc_en;
  assign alloc_bus.areg = alloc_areg;
  assign alloc_rdy      = alloc_bus.rdy;
  assign alloc_preg     = alloc_bus.preg;
  assign alloc_ppreg    = alloc_bus.ppreg;

  // ------------------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------------------

  free_list #(
    .p_num_phys_regs (p_num_phys_regs)
  ) free_list0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .alloc        (alloc_bus.free_list_mp),
    .commit_val   (commit_val),
    .commit_ppreg (commit_ppreg)
  );

  map_table map_table0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .alloc        (alloc_bus.map_mp),
    .lookup0_areg (lookup0_areg),
    .lookup1_areg (lookup1_areg),
    .lookup0_preg (lookup0_preg),
    .lookup1_preg (lookup1_preg)
  );

  // Pending bits indexed by the map outputs
  pending_table #(
    .p_num_phys_regs (p_num_phys_regs)
  ) pending_table0 (
    .clk             (clk),
    .arst_n          (arst_n),
    .alloc           (alloc_bus.pend_mp),
    .complete_val    (complete_val),
    .complete_preg   (complete_preg),
    .lookup0_preg    (lookup0_preg),
    .lookup1_preg    (lookup1_preg),
    .lookup0_pending (lookup0_pending),
    .lookup1_pending (lookup1_pending)
  );

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // A valid lookup always lands inside the configured pool
  a_lookup0_in_pool: assert property (@(posedge clk) disable iff (!arst_n)
    lookup0_en |-> (lookup0_preg < p_num_phys_regs))
    else $error("rename_table: lookup0 preg %0d outside the pool", lookup0_preg);

  a_lookup1_in_pool: assert property (@(posedge clk) disable iff (!arst_n)
    lookup1_en |-> (lookup1_preg < p_num_phys_regs))
    else $error("rename_table: lookup1 preg %0d outside the pool", lookup1_preg);

endmodule

// File: sim/rename_table_tb.sv
/*
 * Testbench for the rename stage. Runs directed and random traffic into
 * rename_table and checks every cycle against a reference model.
 * Built and run by run_sim.sh.
 */

`timescale 1ns/10ps

module rename_table_tb;

  import arch_pkg::*;
  import phys_pkg::*;

  localparam int n_phys          = 40;
  localparam int n_spare         = n_phys - num_arch_regs;
  localparam int clk_period      = 8;
  localparam int reset_cycles    = 16;
  localparam int directed_cycles = 64;
  localparam int n_random        = 400;
  localparam int n_ops           = reset_cycles + directed_cycles + n_random;
  localparam int watchdog_ns     = (n_ops + 100) * clk_period;

  logic  clk;
  logic  arst_n;
  logic  alloc_en;
  areg_t alloc_areg;
  logic  alloc_rdy;
  preg_t alloc_preg;
  preg_t alloc_ppreg;
  logic  lookup0_en;
  areg_t lookup0_areg;
  preg_t lookup0_preg;
  logic  lookup0_pending;
  logic  lookup1_en;
  areg_t lookup1_areg;
  preg_t lookup1_preg;
  logic  lookup1_pending;
  logic  complete_val;
  preg_t complete_preg;
  logic  commit_val;
  preg_t commit_ppreg;

  int    seed = 51063;
  int    n_mismatch;
  int    n_other;
  string test_name;

  // Reference model of map, pending bits, free FIFO and displaced registers
  preg_t model_map [num_arch_regs];
  bit    model_pend [n_phys];
  preg_t free_q [$];
  preg_t displaced_q [$];

  rename_table #(
    .p_num_phys_regs (n_phys)
  ) dut0 (
    .clk             (clk),
    .arst_n          (arst_n),
    .alloc_en        (alloc_en),
    .alloc_areg      (alloc_areg),
    .alloc_rdy       (alloc_rdy),
    .alloc_preg      (alloc_preg),
    .alloc_ppreg     (alloc_ppreg),
    .lookup0_en      (lookup0_en),
    .lookup0_areg    (lookup0_areg),
    .lookup0_preg    (lookup0_preg),
    .lookup0_pending (lookup0_pending),
    .lookup1_en      (lookup1_en),
    .lookup1_areg    (lookup1_areg),
    .lookup1_preg    (lookup1_preg),
    .lookup1_pending (lookup1_pending),
    .complete_val    (complete_val),
    .complete_preg   (complete_preg),
    .commit_val      (commit_val),
    .commit_ppreg    (commit_ppreg)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // Identity map with nothing pending and spares queued ascending
  function automatic void reset_model();
    free_q.delete();
    displaced_q.delete();
    for (int a = 0; a < num_arch_regs; a++) begin
      model_map[a] = preg_t'(a);
    end
    for (int p = 0; p < n_phys; p++) begin
      model_pend[p] = 1'b0;
      if (p >= num_arch_regs) begin
        free_q.push_back(preg_t'(p));
      end
    end
  endfunction

  // Expected outputs for the inputs of the current cycle
  function automatic void predict(
    input  areg_t a_areg,
    input  areg_t l0_areg,
    input  areg_t l1_areg,
    output logic  e_rdy,
    output preg_t e_preg,
    output preg_t e_ppreg,
    output preg_t e_l0_preg,
    output logic  e_l0_pend,
    output preg_t e_l1_preg,
    output logic  e_l1_pend
  );
    e_rdy  = (free_q.size() != 0);
    e_preg = '0;
    if (e_rdy) begin
      e_preg = free_q[0];
    end
    e_ppreg   = model_map[a_areg];
    e_l0_preg = model_map[l0_areg];
    e_l0_pend = model_pend[e_l0_preg];
    e_l1_preg = model_map[l1_areg];
    e_l1_pend = model_pend[e_l1_preg];
  endfunction

  // Applied after the edge with the pop ahead of the commit push
  function automatic void update_model(
    input logic  fire,
    input areg_t areg,
    input logic  cval,
    input preg_t cpreg,
    input logic  mval,
    input preg_t mppreg
  );
    preg_t fresh;
    int    idx;
    idx = -1;
    if (cval) begin
      model_pend[cpreg] = 1'b0;
    end
    if (fire) begin
      fresh = free_q.pop_front();
      displaced_q.push_back(model_map[areg]);
      model_map[areg]   = fresh;
      model_pend[fresh] = 1'b1;
    end
    if (mval) begin
      for (int i = 0; i < displaced_q.size(); i++) begin
        if (displaced_q[i] == mppreg) begin
          idx = i;
        end
      end
      if (idx >= 0) begin
        displaced_q.delete(idx);
      end
      free_q.push_back(mppreg);
    end
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected)
    else begin
      n_mismatch++;
      $display("mismatch %s %s: expected %0d actual %0d",
               test_name, what, expected, actual);
    end
  endtask

  // --------------------------------------------------------------------------
  // Comparison in the middle of the low phase
  // --------------------------------------------------------------------------

  initial begin : compare
    logic  e_rdy;
    preg_t e_preg;
    preg_t e_ppreg;
    preg_t e_l0_preg;
    logic  e_l0_pend;
    preg_t e_l1_preg;
    logic  e_l1_pend;
    logic  c_fire;
    areg_t c_areg;
    logic  c_cval;
    preg_t c_cpreg;
    logic  c_mval;
    preg_t c_mppreg;
    wait (arst_n === 1'b1);
    forever begin
      #2;
      predict(alloc_areg, lookup0_areg, lookup1_areg, e_rdy, e_preg, e_ppreg,
              e_l0_preg, e_l0_pend, e_l1_preg, e_l1_pend);
      check_value("alloc_rdy", int'(e_rdy), int'(alloc_rdy));
      if (e_rdy) begin
        check_value("alloc_preg", int'(e_preg), int'(alloc_preg));
      end
      check_value("alloc_ppreg", int'(e_ppreg), int'(alloc_ppreg));
      check_value("lookup0_preg", int'(e_l0_preg), int'(lookup0_preg));
      check_value("lookup0_pending", int'(e_l0_pend), int'(lookup0_pending));
      check_value("lookup1_preg", int'(e_l1_preg), int'(lookup1_preg));
      check_value("lookup1_pending", int'(e_l1_pend), int'(lookup1_pending));
      c_fire   = alloc_en && e_rdy;
      c_areg   = alloc_areg;
      c_cval   = complete_val;
      c_cpreg  = complete_preg;
      c_mval   = commit_val;
      c_mppreg = commit_ppreg;
      @(posedge clk);
      update_model(c_fire, c_areg, c_cval, c_cpreg, c_mval, c_mppreg);
      @(negedge clk);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // One-shot inputs drop back each falling edge
  task automatic start_cycle();
    @(negedge clk);
    alloc_en     = 1'b0;
    complete_val = 1'b0;
    commit_val   = 1'b0;
  endtask

  // Completions pick pending registers and commits pick completed ones
  task automatic drive_random_cycle();
    preg_t busy [$];
    preg_t ready [$];
    int    pick;
    start_cycle();
    for (int p = 0; p < n_phys; p++) begin
      if (model_pend[p]) begin
        busy.push_back(preg_t'(p));
      end
    end
    foreach (displaced_q[i]) begin
      if (!model_pend[displaced_q[i]]) begin
        ready.push_back(displaced_q[i]);
      end
    end
    lookup0_en   = ($random(seed) & 1) != 0;
    lookup0_areg = areg_t'($random(seed));
    lookup1_en   = ($random(seed) & 1) != 0;
    lookup1_areg = areg_t'($random(seed));
    if (free_q.size() != 0 && ($random(seed) & 1) != 0) begin
      alloc_en   = 1'b1;
      alloc_areg = areg_t'($random(seed));
    end
    if (busy.size() != 0 && ($random(seed) & 3) != 0) begin
      pick          = $unsigned($random(seed)) % busy.size();
      complete_val  = 1'b1;
      complete_preg = busy[pick];
    end
    if (ready.size() != 0 && ($random(seed) & 3) != 0) begin
      pick         = $unsigned($random(seed)) % ready.size();
      commit_val   = 1'b1;
      commit_ppreg = ready[pick];
    end
  endtask

  initial begin : stimulus
    n_mismatch    = 0;
    n_other       = 0;
    test_name     = "reset_state";
    arst_n        = 1'b0;
    alloc_en      = 1'b0;
    alloc_areg    = '0;
    lookup0_en    = 1'b0;
    lookup0_areg  = '0;
    lookup1_en    = 1'b0;
    lookup1_areg  = '0;
    complete_val  = 1'b0;
    complete_preg = '0;
    commit_val    = 1'b0;
    commit_ppreg  = '0;
    reset_model();
    repeat (reset_cycles) @(negedge clk);
    arst_n = 1'b1;

    // Identity map on both ports with nothing pending
    for (int a = 0; a < num_arch_regs; a++) begin
      start_cycle();
      lookup0_en   = 1'b1;
      lookup1_en   = 1'b1;
      lookup0_areg = areg_t'(a);
      lookup1_areg = areg_t'(num_arch_regs - 1 - a);
      #1;
      check_value("identity", a, int'(lookup0_preg));
      check_value("ready", 1, int'(alloc_rdy));
    end

    // First allocation sees the old mapping this cycle
    test_name = "allocation";
    start_cycle();
    alloc_en     = 1'b1;
    alloc_areg   = 5'd1;
    lookup0_areg = 5'd1;
    lookup1_areg = 5'd1;
    #1;
    check_value("first ppreg", 1, int'(alloc_ppreg));
    check_value("first preg", num_arch_regs, int'(alloc_preg));
    check_value("same cycle lookup", 1, int'(lookup0_preg));
    start_cycle();
    #1;
    check_value("new mapping", num_arch_regs, int'(lookup1_preg));
    check_value("new pending", 1, int'(lookup1_pending));

    // Drain the rest of the pool
    test_name = "capacity";
    for (int k = 1; k < n_spare; k++) begin
      start_cycle();
      alloc_en   = 1'b1;
      alloc_areg = areg_t'(k + 1);
      #1;
      check_value("ascending preg", num_arch_regs + k, int'(alloc_preg));
    end
    start_cycle();
    #1;
    check_value("empty", 0, int'(alloc_rdy));

    test_name = "completion";
    start_cycle();
    complete_val  = 1'b1;
    complete_preg = preg_t'(num_arch_regs);
    lookup0_areg  = 5'd1;
    #1;
    check_value("still pending", 1, int'(lookup0_pending));
    start_cycle();
    #1;
    check_value("cleared", 0, int'(lookup0_pending));

    // Freed registers come back oldest first
    test_name = "commit_reuse";
    start_cycle();
    commit_val   = 1'b1;
    commit_ppreg = 6'd1;
    start_cycle();
    commit_val   = 1'b1;
    commit_ppreg = 6'd2;
    #1;
    check_value("ready after commit", 1, int'(alloc_rdy));
    for (int n = 1; n <= 3; n++) begin
      start_cycle();
      alloc_en   = 1'b1;
      alloc_areg = areg_t'(9 + n);
      if (n == 1) begin
        commit_val   = 1'b1;
        commit_ppreg = 6'd3;
      end
      #1;
      check_value("fifo order", n, int'(alloc_preg));
    end
    start_cycle();
    #1;
    check_value("empty again", 0, int'(alloc_rdy));

    test_name = "random_mix";
    repeat (n_random) drive_random_cycle();
    start_cycle();
    @(posedge clk);

    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    n_other++;
    $display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: sources.f
logic/arch_pkg.sv
logic/phys_pkg.sv
logic/alloc_if.sv
logic/free_list.sv
logic/map_table.sv
logic/pending_table.sv
logic/rename_table.sv
sim/rename_table_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the rename stage testbench.
# The log is searched for the fail message to decide the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module rename_table_tb \
  -f sources.f \
  --Mdir obj_dir \
  -o rename_table_sim

status=0
./obj_dir/rename_table_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0
